/* l15_adapter_pkg.sv */
// Shared L1.5 message codes and cache port constants, imported by every adapter module
package l15_adapter_pkg;

    // L1.5 request types
    localparam logic [4:0] L15_LOAD_RQ  = 5'b00000;
    localparam logic [4:0] L15_STORE_RQ = 5'b00001;
    localparam logic [4:0] L15_IMISS_RQ = 5'b10000;

    // L1.5 return types
    localparam logic [3:0] L15_LOAD_RET  = 4'b0000;
    localparam logic [3:0] L15_IFILL_RET = 4'b0001;
    localparam logic [3:0] L15_ST_ACK    = 4'b0100;
    localparam logic [3:0] L15_ERR_RET   = 4'b1100;

    // Message size, log2(bytes)+1
    localparam logic [2:0] MSG_SIZE_0B  = 3'd0;
    localparam logic [2:0] MSG_SIZE_1B  = 3'd1;
    localparam logic [2:0] MSG_SIZE_2B  = 3'd2;
    localparam logic [2:0] MSG_SIZE_4B  = 3'd3;
    localparam logic [2:0] MSG_SIZE_8B  = 3'd4;
    localparam logic [2:0] MSG_SIZE_16B = 3'd5;
    localparam logic [2:0] MSG_SIZE_32B = 3'd6;
    localparam logic [2:0] MSG_SIZE_64B = 3'd7;

    // Instruction fill sizes
    localparam logic [2:0] IFILL_CACHED_SIZE   = MSG_SIZE_64B; // Full line
    localparam logic [2:0] IFILL_UNCACHED_SIZE = MSG_SIZE_8B;  // One dword

    // Position of each source in the one-hot port index
    localparam int PORT_ICACHE   = 0;
    localparam int PORT_DCACHE   = 1;
    localparam int PORT_WBUF     = 2;
    localparam int PORT_UNC      = 3;
    localparam int NUM_SRC_PORTS = 4;

    // Cache memory commands
    localparam logic [1:0] MEM_READ  = 2'b00;
    localparam logic [1:0] MEM_WRITE = 2'b01;

    // L1.5 request data is a single dword
    localparam int L15_DATA_WIDTH = 64;

    // Physical address width
    localparam int PA_WIDTH = 40;

endpackage

/* l15_req_encoder.sv */
// Translates one cache memory request into L1.5 request fields, purely combinational
`timescale 1ns/100ps

module l15_req_encoder #(
    parameter int MemDataWidth = 128,
    parameter bit SwapEndian   = 1'b1
) (
    input  logic [l15_adapter_pkg::NUM_SRC_PORTS-1:0] req_index_i,     // One-hot source port
    input  logic [1:0]                                 req_command_i,
    input  logic [l15_adapter_pkg::PA_WIDTH-1:0]       req_addr_i,
    input  logic [2:0]                                 req_size_i,      // log2 bytes
    input  logic                                       req_cacheable_i,
    input  logic [MemDataWidth-1:0]                    req_wdata_i,
    input  logic [MemDataWidth/8-1:0]                  req_wbe_i,
    output logic [4:0]                                 l15_rqtype_o,
    output logic                                       l15_nc_o,
    output logic [2:0]                                 l15_size_o,
    output logic [l15_adapter_pkg::PA_WIDTH-1:0]       l15_address_o,
    output logic [l15_adapter_pkg::L15_DATA_WIDTH-1:0] l15_data_o,
    output logic [7:0]                                 l15_be_o
);
    import l15_adapter_pkg::*;

    localparam int ByteNum  = L15_DATA_WIDTH / 8;          // Bytes per dword
    localparam int WordNum  = MemDataWidth / L15_DATA_WIDTH;
    localparam int SelWidth = (WordNum > 1) ? $clog2(WordNum) : 1;
    localparam int CntWidth = $clog2(MemDataWidth / 8) + 1;

    // Sub-dword stores are copied into the top and bottom lanes
    function automatic logic [63:0] rep_data64(input logic [63:0] data, input logic [7:0] be);
        logic [63:0] rep;
        rep = data;
        case (be)
            8'b0000_0001: {rep[63:56], rep[7:0]} = {2{data[7:0]}};
            8'b0000_0010: {rep[63:56], rep[7:0]} = {2{data[15:8]}};
            8'b0000_0100: {rep[63:56], rep[7:0]} = {2{data[23:16]}};
            8'b0000_1000: {rep[63:56], rep[7:0]} = {2{data[31:24]}};
            8'b0001_0000: {rep[63:56], rep[7:0]} = {2{data[39:32]}};
            8'b0010_0000: {rep[63:56], rep[7:0]} = {2{data[47:40]}};
            8'b0100_0000: {rep[63:56], rep[7:0]} = {2{data[55:48]}};
            8'b1000_0000: {rep[63:56], rep[7:0]} = {2{data[63:56]}};
            8'b0000_0011: {rep[63:48], rep[15:0]} = {2{data[15:0]}};
            8'b0000_1100: {rep[63:48], rep[15:0]} = {2{data[31:16]}};
            8'b0011_0000: {rep[63:48], rep[15:0]} = {2{data[47:32]}};
            8'b1100_0000: {rep[63:48], rep[15:0]} = {2{data[63:48]}};
            8'b0000_1111: rep = {2{data[31:0]}};
            8'b1111_0000: rep = {2{data[63:32]}};
            default: ;                                      // Full dword as is
        endcase
        return rep;
    endfunction

    logic                   req_is_ifill;
    logic                   req_is_load;
    logic                   req_is_wbuf_st;
    logic [CntWidth-1:0]    num_ones;
    logic [2:0]             wt_size;
    logic [ByteNum-1:0]     be_fold;      // Byte mask OR-ed down to one dword
    logic [2:0]             first_one;
    logic [SelWidth-1:0]    word_sel;
    logic [63:0]            dword;
    logic [63:0]            dword_swap;
    logic [7:0]             be_swap;

    // Classification from port and command
    assign req_is_ifill   = req_index_i[PORT_ICACHE];
    assign req_is_load    = (req_index_i[PORT_DCACHE] | req_index_i[PORT_UNC])
                          & (req_command_i == MEM_READ);
    assign req_is_wbuf_st = req_index_i[PORT_WBUF] & (req_command_i == MEM_WRITE);

    assign l15_rqtype_o = req_is_ifill ? L15_IMISS_RQ :
                          req_is_load  ? L15_LOAD_RQ  : L15_STORE_RQ; // Store is what remains
    assign l15_nc_o     = ~req_cacheable_i;

    assign num_ones = CntWidth'($countones(req_wbe_i));

    // Size code of a power-of-two byte count
    always_comb begin
        wt_size = MSG_SIZE_64B;                             // Odd counts fall back here
        if (num_ones == '0) wt_size = MSG_SIZE_0B;
        for (int k = 0; k < 7; k++) begin
            if (int'(num_ones) == (1 << k)) wt_size = 3'(k + 1);
        end
    end

    assign l15_size_o = req_is_ifill   ? (req_cacheable_i ? IFILL_CACHED_SIZE
                                                          : IFILL_UNCACHED_SIZE) :
                        req_is_wbuf_st ? wt_size :
                                         req_size_i + 3'd1;

    always_comb begin
        be_fold = '0;
        for (int i = 0; i < WordNum; i++) be_fold |= req_wbe_i[i*ByteNum +: ByteNum];
    end

    // Lowest set byte, scanned downward so the last hit wins
    always_comb begin
        first_one = '0;
        for (int i = ByteNum - 1; i >= 0; i--) begin
            if (be_fold[i]) first_one = 3'(i);
        end
    end

    assign l15_address_o = req_is_wbuf_st ? {req_addr_i[PA_WIDTH-1:3], first_one} : req_addr_i;

    // Dword picked by the address
    assign word_sel = req_addr_i[3 +: SelWidth];
    always_comb begin
        dword = req_wdata_i[63:0];
        for (int i = 1; i < WordNum; i++) begin
            if (int'(word_sel) == i) dword = req_wdata_i[i*64 +: 64];
        end
    end

    // OpenPiton is big endian
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            dword_swap[i*8 +: 8] = dword[56 - i*8 +: 8];
            be_swap[7 - i]       = be_fold[i];
        end
    end

    assign l15_data_o = SwapEndian ? rep_data64(dword_swap, be_swap) : dword;
    assign l15_be_o   = SwapEndian ? be_swap : be_fold;

endmodule

/* l15_tid_pool.sv */
// Free list of L1.5 thread ids, full of every id at reset, popped on accept and refilled on return
`timescale 1ns/100ps

module l15_tid_pool #(
    parameter int TidWidth = 2
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                push_i,      // Return acked
    input  logic [TidWidth-1:0] push_tid_i,
    input  logic                pop_i,       // Request accepted
    output logic                avail_o,
    output logic [TidWidth-1:0] tid_o
);

    localparam int Depth = 2 ** TidWidth;

    logic [TidWidth-1:0] mem_q [Depth];
    logic [TidWidth-1:0] rptr_q;             // Wraps on its own
    logic [TidWidth-1:0] wptr_q;
    logic [TidWidth:0]   count_q;
    logic                do_push;
    logic                do_pop;

    assign avail_o = (count_q != '0);
    assign tid_o   = mem_q[rptr_q];          // Head of the list

    assign do_pop  = pop_i & avail_o;
    assign do_push = push_i & (count_q != (TidWidth + 1)'(Depth)); // Never full in practice

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < Depth; i++) begin
                mem_q[i] <= TidWidth'(i);    // Ids in ascending order
            end
            rptr_q  <= '0;
            wptr_q  <= '0;
            count_q <= (TidWidth + 1)'(Depth);
        end else begin
            if (do_push) begin
                mem_q[wptr_q] <= push_tid_i;
                wptr_q        <= wptr_q + 1'b1;
            end
            if (do_pop) rptr_q <= rptr_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;                   // Both or neither
            endcase
        end
    end

endmodule

/* l15_req_fsm.sv */
// Request handshake FSM, raises val until header_ack then waits for ack to accept the request
`timescale 1ns/100ps

module l15_req_fsm (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic req_valid_i,
    input  logic tid_avail_i,
    input  logic l15_header_ack_i,
    input  logic l15_ack_i,
    output logic l15_val_o,
    output logic req_ready_o,
    output logic accept_o       // Pop the tid and write the table
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HEADER,
        WAIT_ACK
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   accept;

    always_comb begin
        state_d   = state_q;
        l15_val_o = 1'b0;
        accept    = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i && tid_avail_i) begin
                    l15_val_o = 1'b1;
                    if (l15_header_ack_i && l15_ack_i) begin
                        accept = 1'b1;              // Both acks at once
                    end else if (l15_header_ack_i) begin
                        state_d = WAIT_ACK;
                    end else begin
                        state_d = WAIT_HEADER;
                    end
                end
            end
            WAIT_HEADER: begin
                l15_val_o = 1'b1;                   // Held until header is taken
                if (req_valid_i && l15_header_ack_i) begin
                    if (l15_ack_i) begin
                        accept  = 1'b1;
                        state_d = IDLE;
                    end else begin
                        state_d = WAIT_ACK;
                    end
                end
            end
            WAIT_ACK: begin
                // val low, request fields stay put
                if (req_valid_i && l15_ack_i) begin
                    accept  = 1'b1;
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign req_ready_o = accept;
    assign accept_o    = accept;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) state_q <= IDLE;
        else         state_q <= state_d;
    end

endmodule

/* l15_resp_router.sv */
// Return path, restores requester id and port from a per-thread table and swaps return data
`timescale 1ns/100ps

module l15_resp_router #(
    parameter int TidWidth     = 2,
    parameter int MemIdWidth   = 4,
    parameter int PortIdWidth  = 3,
    parameter int MemDataWidth = 128,
    parameter bit SwapEndian   = 1'b1
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    accept_i,
    input  logic [TidWidth-1:0]     accept_tid_i,
    input  logic [MemIdWidth-1:0]   req_id_i,
    input  logic [PortIdWidth-1:0]  req_pid_i,
    input  logic                    rtrn_val_i,
    input  logic [3:0]              rtrn_returntype_i,
    input  logic [TidWidth-1:0]     rtrn_threadid_i,
    input  logic [MemDataWidth-1:0] rtrn_data_i,
    input  logic                    resp_ready_i,
    output logic                    resp_valid_o,
    output logic [PortIdWidth-1:0]  resp_pid_o,
    output logic [MemIdWidth-1:0]   resp_id_o,
    output logic [MemDataWidth-1:0] resp_data_o,
    output logic                    resp_error_o,
    output logic                    l15_req_ack_o,
    output logic                    free_o          // Tid goes back to the pool
);
    import l15_adapter_pkg::*;

    localparam int Depth   = 2 ** TidWidth;
    localparam int WordNum = MemDataWidth / L15_DATA_WIDTH;

    logic [MemIdWidth-1:0]  id_q  [Depth];
    logic [PortIdWidth-1:0] pid_q [Depth];

    // Table written when the L1.5 accepts the request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < Depth; i++) begin
                id_q[i]  <= '0;
                pid_q[i] <= '0;
            end
        end else if (accept_i) begin
            id_q[accept_tid_i]  <= req_id_i;
            pid_q[accept_tid_i] <= req_pid_i;
        end
    end

    assign resp_valid_o  = rtrn_val_i;
    assign resp_id_o     = id_q[rtrn_threadid_i];   // Same-cycle lookup
    assign resp_pid_o    = pid_q[rtrn_threadid_i];
    assign resp_error_o  = (rtrn_returntype_i == L15_ERR_RET);
    assign l15_req_ack_o = rtrn_val_i & resp_ready_i; // Held off under back-pressure
    assign free_o        = rtrn_val_i & resp_ready_i;

    // Byte reverse within each dword
    always_comb begin
        resp_data_o = rtrn_data_i;
        if (SwapEndian) begin
            for (int w = 0; w < WordNum; w++) begin
                for (int b = 0; b < 8; b++) begin
                    resp_data_o[w*64 + b*8 +: 8] = rtrn_data_i[w*64 + 56 - b*8 +: 8];
                end
            end
        end
    end

endmodule

/* hpdc_l15_adapter.sv */
// Top of the cache to L1.5 adapter, connects encoder, tid pool, handshake FSM and return router
`timescale 1ns/100ps

module hpdc_l15_adapter #(
    parameter int TidWidth     = 2,
    parameter int MemIdWidth   = 4,
    parameter int PortIdWidth  = 3,
    parameter int MemDataWidth = 128,
    parameter bit SwapEndian   = 1'b1
) (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    // Cache request side
    input  logic                                       req_valid_i,
    input  logic [l15_adapter_pkg::NUM_SRC_PORTS-1:0] req_index_i,
    input  logic [1:0]                                 req_command_i,
    input  logic [l15_adapter_pkg::PA_WIDTH-1:0]       req_addr_i,
    input  logic [2:0]                                 req_size_i,
    input  logic                                       req_cacheable_i,
    input  logic [MemIdWidth-1:0]                      req_id_i,
    input  logic [PortIdWidth-1:0]                     req_pid_i,
    input  logic [MemDataWidth-1:0]                    req_wdata_i,
    input  logic [MemDataWidth/8-1:0]                  req_wbe_i,
    output logic                                       req_ready_o,
    // Cache response side
    input  logic                                       resp_ready_i,
    output logic                                       resp_valid_o,
    output logic [PortIdWidth-1:0]                     resp_pid_o,
    output logic [MemIdWidth-1:0]                      resp_id_o,
    output logic [MemDataWidth-1:0]                    resp_data_o,
    output logic                                       resp_error_o,
    // L1.5 request
    output logic                                       l15_val_o,
    output logic [4:0]                                 l15_rqtype_o,
    output logic                                       l15_nc_o,
    output logic [2:0]                                 l15_size_o,
    output logic [TidWidth-1:0]                        l15_threadid_o,
    output logic [l15_adapter_pkg::PA_WIDTH-1:0]       l15_address_o,
    output logic [l15_adapter_pkg::L15_DATA_WIDTH-1:0] l15_data_o,
    output logic [7:0]                                 l15_be_o,
    output logic                                       l15_req_ack_o,
    input  logic                                       l15_header_ack_i,
    input  logic                                       l15_ack_i,
    // L1.5 return
    input  logic                                       rtrn_val_i,
    input  logic [3:0]                                 rtrn_returntype_i,
    input  logic [TidWidth-1:0]                        rtrn_threadid_i,
    input  logic [MemDataWidth-1:0]                    rtrn_data_i
);

    logic tid_avail;
    logic accept;     // Request taken by the L1.5
    logic tid_free;   // Return acked

    l15_req_encoder #(
        .MemDataWidth(MemDataWidth),
        .SwapEndian  (SwapEndian)
    ) l15_req_encoder_i (
        .req_index_i, .req_command_i, .req_addr_i, .req_size_i, .req_cacheable_i,
        .req_wdata_i, .req_wbe_i,
        .l15_rqtype_o, .l15_nc_o, .l15_size_o, .l15_address_o, .l15_data_o, .l15_be_o
    );

    l15_tid_pool #(
        .TidWidth(TidWidth)
    ) l15_tid_pool_i (
        .clk_i, .rst_ni,
        .push_i    (tid_free),
        .push_tid_i(rtrn_threadid_i),
        .pop_i     (accept),
        .avail_o   (tid_avail),
        .tid_o     (l15_threadid_o)
    );

    l15_req_fsm l15_req_fsm_i (
        .clk_i, .rst_ni, .req_valid_i,
        .tid_avail_i(tid_avail),
        .l15_header_ack_i, .l15_ack_i, .l15_val_o, .req_ready_o,
        .accept_o   (accept)
    );

    l15_resp_router #(
        .TidWidth    (TidWidth),
        .MemIdWidth  (MemIdWidth),
        .PortIdWidth (PortIdWidth),
        .MemDataWidth(MemDataWidth),
        .SwapEndian  (SwapEndian)
    ) l15_resp_router_i (
        .clk_i, .rst_ni,
        .accept_i    (accept),
        .accept_tid_i(l15_threadid_o),  // Tid at the pool head
        .req_id_i, .req_pid_i,
        .rtrn_val_i, .rtrn_returntype_i, .rtrn_threadid_i, .rtrn_data_i, .resp_ready_i,
        .resp_valid_o, .resp_pid_o, .resp_id_o, .resp_data_o, .resp_error_o, .l15_req_ack_o,
        .free_o      (tid_free)
    );

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset source, 20 ns clock with reset held low for the first cycles
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PeriodNs    = 20,
    parameter int ResetCycles = 3
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;                               // Reset from time zero
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o) rst_no = 1'b1;              // Released away from the sampling edge
    end

    always #(PeriodNs / 2) clk_o = ~clk_o;

endmodule

/* tb_hpdc_l15_adapter.sv */
// Testbench for the cache to L1.5 adapter with an L1.5 responder model and assertion checks
`timescale 1ns/100ps

module tb_hpdc_l15_adapter;
    import l15_adapter_pkg::*;

    localparam int NumReq = 40;
    localparam int Period = 20;

    logic clk_i, rst_ni;
    logic req_valid_i, req_cacheable_i, resp_ready_i, l15_header_ack_i, l15_ack_i, rtrn_val_i;
    logic [3:0] req_index_i, rtrn_returntype_i;
    logic [1:0] req_command_i, rtrn_threadid_i, l15_threadid_o;
    logic [39:0] req_addr_i, l15_address_o;
    logic [2:0] req_size_i, l15_size_o, resp_pid_o, req_pid_i;
    logic [3:0] req_id_i, resp_id_o;
    logic [127:0] req_wdata_i, rtrn_data_i, resp_data_o;
    logic [15:0] req_wbe_i;
    logic req_ready_o, resp_valid_o, resp_error_o, l15_val_o, l15_nc_o, l15_req_ack_o;
    logic [4:0] l15_rqtype_o;
    logic [63:0] l15_data_o;
    logic [7:0] l15_be_o;

    logic [31:0] lfsr = 32'h2ce1;
    int errors = 0, issued = 0, returned = 0;
    logic returns_en = 1'b0;
    logic [3:0] out_valid = '0;                      // Outstanding tids
    logic [3:0] exp_id [4];
    logic [2:0] exp_pid [4];
    logic [3:0] exp_rtype [4];
    logic hdr_seen, val_pend, acked_q;
    logic [2:0] exp_st_size;
    logic [39:0] exp_st_addr;
    logic [7:0] exp_st_be;
    logic [63:0] exp_st_data;

    tb_clk_gen #(.PeriodNs(Period), .ResetCycles(3)) tb_clk_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

    hpdc_l15_adapter hpdc_l15_adapter_i (.*);

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [127:0] swap_dwords(input logic [127:0] d);
        logic [127:0] s;
        for (int w = 0; w < 2; w++)
            for (int b = 0; b < 8; b++) s[w*64 + b*8 +: 8] = d[w*64 + (7-b)*8 +: 8];
        return s;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        errors++;
        $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
    endtask

    wire is_ifill = (req_index_i == 4'b0001);
    wire is_load  = (req_index_i == 4'b0010) || (req_index_i == 4'b1000);
    wire is_store = (req_index_i == 4'b0100);

    // Load and ifill translation
    a_load_type: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l15_val_o && is_load) |-> l15_rqtype_o == L15_LOAD_RQ)
        else report_mismatch("load_type", L15_LOAD_RQ, $sampled(l15_rqtype_o));
    a_load_size: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l15_val_o && is_load) |-> l15_size_o == req_size_i + 3'd1)
        else report_mismatch("load_size", $sampled(req_size_i) + 3'd1, $sampled(l15_size_o));
    a_load_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l15_val_o && !is_store) |-> (l15_address_o == req_addr_i && l15_nc_o == !req_cacheable_i))
        else report_mismatch("load_addr_nc", {$sampled(req_addr_i), !$sampled(req_cacheable_i)},
                             {$sampled(l15_address_o), $sampled(l15_nc_o)});
    a_ifill: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l15_val_o && is_ifill) |->
        (l15_rqtype_o == L15_IMISS_RQ && l15_size_o == (req_cacheable_i ? 3'd7 : 3'd4)))
        else report_mismatch("ifill_type_size",
                             {L15_IMISS_RQ, ($sampled(req_cacheable_i) ? 3'd7 : 3'd4)},
                             {$sampled(l15_rqtype_o), $sampled(l15_size_o)});
    // Store alignment and data
    a_st_size: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l15_val_o && is_store) |-> (l15_size_o == exp_st_size && l15_rqtype_o == L15_STORE_RQ))
        else report_mismatch("store_type_size", {L15_STORE_RQ, exp_st_size},
                             {$sampled(l15_rqtype_o), $sampled(l15_size_o)});
    a_st_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l15_val_o && is_store) |-> l15_address_o == exp_st_addr)
        else report_mismatch("store_addr", exp_st_addr, $sampled(l15_address_o));
    a_st_be: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l15_val_o && is_store) |-> l15_be_o == exp_st_be)
        else report_mismatch("store_be", exp_st_be, $sampled(l15_be_o));
    a_st_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l15_val_o && is_store) |-> l15_data_o == exp_st_data)
        else report_mismatch("store_data", exp_st_data, $sampled(l15_data_o));
    // Handshake
    a_reset: assert property (@(posedge clk_i) !rst_ni |-> (!l15_val_o && !req_ready_o))
        else report_mismatch("reset_outputs", 0, {$sampled(l15_val_o), $sampled(req_ready_o)});
    a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_ready_o |-> (l15_ack_i && (l15_header_ack_i || hdr_seen)))
        else report_mismatch("ready_needs_acks", 2'b11,
                             {$sampled(l15_ack_i), $sampled(l15_header_ack_i || hdr_seen)});
    a_val_hold: assert property (@(posedge clk_i) disable iff (!rst_ni) val_pend |-> l15_val_o)
        else report_mismatch("val_held", 1, $sampled(l15_val_o));
    a_val_drop: assert property (@(posedge clk_i) disable iff (!rst_ni) hdr_seen |-> !l15_val_o)
        else report_mismatch("val_dropped", 0, $sampled(l15_val_o));
    // Tid pool
    a_tid_reuse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_ready_o |-> !out_valid[l15_threadid_o])
        else report_mismatch("tid_reuse", 0, $sampled(l15_threadid_o));
    a_pool_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (out_valid == 4'hf) |-> !l15_val_o)
        else report_mismatch("pool_empty_val", 0, $sampled(l15_val_o));
    // Return routing
    a_rtn_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_valid_o == rtrn_val_i)
        else report_mismatch("return_valid", $sampled(rtrn_val_i), $sampled(resp_valid_o));
    a_rtn_ids: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rtrn_val_i |-> ({resp_id_o, resp_pid_o}
                        == {exp_id[rtrn_threadid_i], exp_pid[rtrn_threadid_i]}))
        else report_mismatch("return_id_pid",
                             {exp_id[$sampled(rtrn_threadid_i)], exp_pid[$sampled(rtrn_threadid_i)]},
                             {$sampled(resp_id_o), $sampled(resp_pid_o)});
    a_rtn_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rtrn_val_i |-> resp_data_o == swap_dwords(rtrn_data_i))
        else report_mismatch("return_data", swap_dwords($sampled(rtrn_data_i)),
                             $sampled(resp_data_o));
    a_rtn_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rtrn_val_i |-> resp_error_o == (exp_rtype[rtrn_threadid_i] == L15_ERR_RET))
        else report_mismatch("return_error", exp_rtype[$sampled(rtrn_threadid_i)] == L15_ERR_RET,
                             $sampled(resp_error_o));
    a_bp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !resp_ready_i |-> !l15_req_ack_o)
        else report_mismatch("backpressure_ack", 0, $sampled(l15_req_ack_o));

    // Bookkeeping on the rising edge, before DUT state moves
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hdr_seen <= 1'b0;
            val_pend <= 1'b0;
            acked_q  <= 1'b0;
        end else begin
            hdr_seen <= req_ready_o ? 1'b0 : (hdr_seen | l15_header_ack_i);
            val_pend <= l15_val_o && !l15_header_ack_i;
            acked_q  <= rtrn_val_i && l15_req_ack_o;
            if (req_ready_o) begin
                out_valid[l15_threadid_o] <= 1'b1;
                exp_id[l15_threadid_o]    <= req_id_i;
                exp_pid[l15_threadid_o]   <= req_pid_i;
                exp_rtype[l15_threadid_o] <= (rand_bits(3) == 0) ? L15_ERR_RET :
                    is_ifill ? L15_IFILL_RET : is_store ? L15_ST_ACK : L15_LOAD_RET;
            end
            if (rtrn_val_i && l15_req_ack_o) begin
                out_valid[rtrn_threadid_i] <= 1'b0;
                returned++;
            end
        end
    end

    // L1.5 header_ack and ack timing
    initial begin
        int d_hdr, d_ack;
        forever begin
            @(negedge clk_i);
            if (rst_ni && l15_val_o) begin
                d_hdr = rand_bits(2);
                d_ack = rand_bits(2);
                repeat (d_hdr) @(negedge clk_i);
                l15_header_ack_i = 1'b1;
                l15_ack_i        = (d_ack == 0);     // Both acks together
                @(negedge clk_i);
                l15_header_ack_i = 1'b0;
                l15_ack_i        = 1'b0;
                if (d_ack > 0) begin
                    repeat (d_ack - 1) @(negedge clk_i);
                    l15_ack_i = 1'b1;
                    @(negedge clk_i);
                    l15_ack_i = 1'b0;
                end
            end
        end
    end

    // Returns in random order with random stalls
    initial begin
        int start;
        forever begin
            @(negedge clk_i);
            resp_ready_i = (rand_bits(2) != 0);
            if (acked_q) rtrn_val_i = 1'b0;
            if (!rtrn_val_i && returns_en && out_valid != 0 && rand_bits(1)) begin
                start = rand_bits(2);
                for (int k = 0; k < 4; k++) begin
                    if (!rtrn_val_i && out_valid[(start + k) % 4]) begin
                        rtrn_threadid_i   = 2'((start + k) % 4);
                        rtrn_val_i        = 1'b1;
                    end
                end
                rtrn_returntype_i = exp_rtype[rtrn_threadid_i];
                rtrn_data_i = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
            end
        end
    end

    task automatic issue_request();
        int kind, s, n, o, w;
        logic [63:0] sw, fld;
        @(negedge clk_i);
        kind = rand_bits(2);
        req_index_i     = 4'b0001 << kind;
        req_command_i   = (kind == PORT_WBUF) ? MEM_WRITE : MEM_READ;
        req_addr_i      = {8'(rand_bits(8)), rand_bits(32)};
        req_size_i      = 3'(rand_bits(2));
        req_cacheable_i = rand_bits(1);
        req_id_i        = rand_bits(4);
        req_pid_i       = rand_bits(3);
        req_wdata_i     = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
        req_wbe_i       = '0;
        if (kind == PORT_WBUF) begin
            s = rand_bits(2);
            n = 1 << s;
            o = (rand_bits(3) & (8 - n)) & 7;        // Naturally aligned group
            w = rand_bits(1);
            req_addr_i[3] = 1'(w);
            req_wbe_i[w*8 +: 8] = 8'(((1 << n) - 1) << o);
            exp_st_size = 3'(s + 1);
            exp_st_addr = {req_addr_i[39:3], 3'(o)};
            exp_st_be   = 8'(((1 << n) - 1) << (8 - o - n));
            for (int b = 0; b < 8; b++) sw[b*8 +: 8] = req_wdata_i[w*64 + (7-b)*8 +: 8];
            fld = sw >> ((8 - o - n) * 8);
            exp_st_data = sw;
            for (int b = 0; b < n && n < 8; b++) begin
                exp_st_data[b*8 +: 8]           = fld[b*8 +: 8];
                exp_st_data[(8 - n + b)*8 +: 8] = fld[b*8 +: 8];
            end
        end
        req_valid_i = 1'b1;
        do @(posedge clk_i); while (!req_ready_o);
        issued++;
        @(negedge clk_i);
        req_valid_i = 1'b0;
        repeat (rand_bits(2)) @(negedge clk_i);
    endtask

    initial begin
        {req_valid_i, req_cacheable_i, l15_header_ack_i, l15_ack_i, rtrn_val_i} = '0;
        {req_index_i, req_command_i, req_addr_i, req_size_i, req_id_i, req_pid_i} = '0;
        {req_wdata_i, req_wbe_i, rtrn_returntype_i, rtrn_threadid_i, rtrn_data_i} = '0;
        resp_ready_i = 1'b1;
        @(posedge rst_ni);
        repeat (4) issue_request();                  // Fill every tid, no returns yet
        fork
            repeat (NumReq - 4) issue_request();
            begin
                repeat (10) @(negedge clk_i);
                returns_en = 1'b1;
            end
        join
        wait (out_valid == 0);
        repeat (2) @(negedge clk_i);
        $display("Checks done: %0d errors, %0d requests, %0d returns", errors, issued, returned);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NumReq * 200 * Period);
        $display("Timeout: requests or returns stopped making progress");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* build.f */
l15_adapter_pkg.sv
l15_req_encoder.sv
l15_tid_pool.sv
l15_req_fsm.sv
l15_resp_router.sv
hpdc_l15_adapter.sv
tb_clk_gen.sv
tb_hpdc_l15_adapter.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the adapter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_hpdc_l15_adapter -f build.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi
exit 1
